// ==== bench/tb_mips_core.sv ====
// MIPS core testbench
`timescale 1ns/1ps
`default_nettype none

`include "mips_cfg.svh"

module tb_mips_core
   import mips_isa_pkg::*, mips_ctrl_pkg::*;
();

   typedef enum logic [2:0] {K_RTYPE, K_ITYPE, K_MEM, K_ZERO, K_BRANCH, K_JUMP, K_RSVD} kind_e;

   // one test row with kind, opcode or funct, operands, random flag and expected word 0
   typedef struct packed {
      kind_e       kind;
      logic [5:0]  code;
      logic [31:0] a;
      logic [31:0] b;
      logic        rnd;
      logic [31:0] want;
   } row_t;

   localparam int NROWS = 29;
   localparam logic [31:0] LFSR_SEED = 32'd85954;
   // x^32 + x^31 + x^29 + x + 1 in right-shifting form
   localparam logic [31:0] LFSR_TAPS = 32'hd000_0001;
   localparam logic [31:0] TEXT_BYTE = `MIPS_TEXT_START;
   localparam logic [29:0] TEXT_WORD = TEXT_BYTE[31:2];

   localparam row_t ROWS [NROWS] = '{
      '{K_RTYPE,  F_ADDU,   32'h7fff_ffff, 32'h0000_0001, 1'b0, 32'h8000_0000},
      '{K_RTYPE,  F_SUBU,   32'h0000_0003, 32'h0000_0005, 1'b0, 32'hffff_fffe},
      '{K_RTYPE,  F_AND,    32'hf0f0_f0f0, 32'hff00_ff00, 1'b0, 32'hf000_f000},
      '{K_RTYPE,  F_OR,     32'hf0f0_f0f0, 32'hff00_ff00, 1'b0, 32'hfff0_fff0},
      '{K_RTYPE,  F_XOR,    32'hf0f0_f0f0, 32'hff00_ff00, 1'b0, 32'h0ff0_0ff0},
      '{K_RTYPE,  F_NOR,    32'hf0f0_f0f0, 32'hff00_ff00, 1'b0, 32'h000f_000f},
      '{K_RTYPE,  F_SLT,    32'hffff_ffff, 32'h0000_0001, 1'b0, 32'h0000_0001},
      '{K_RTYPE,  F_SLTU,   32'hffff_ffff, 32'h0000_0001, 1'b0, 32'h0000_0000},
      '{K_RTYPE,  F_SLL,    32'h0000_0004, 32'h8000_0001, 1'b0, 32'h0000_0010},
      '{K_RTYPE,  F_SRL,    32'h0000_0004, 32'h8000_0000, 1'b0, 32'h0800_0000},
      '{K_RTYPE,  F_SRA,    32'h0000_0004, 32'h8000_0000, 1'b0, 32'hf800_0000},
      '{K_ITYPE,  OP_ADDIU, 32'h0000_0010, 32'h0000_fffe, 1'b0, 32'h0000_000e},
      '{K_ITYPE,  OP_ANDI,  32'hffff_1234, 32'h0000_ff0f, 1'b0, 32'h0000_1204},
      '{K_ITYPE,  OP_ORI,   32'h1234_0000, 32'h0000_8001, 1'b0, 32'h1234_8001},
      '{K_ITYPE,  OP_XORI,  32'hffff_ffff, 32'h0000_8000, 1'b0, 32'hffff_7fff},
      '{K_ITYPE,  OP_LUI,   32'h0000_0000, 32'h0000_abcd, 1'b0, 32'habcd_0000},
      '{K_MEM,    OP_LW,    32'hcafe_f00d, 32'h0000_0000, 1'b0, 32'hcafe_f00d},
      '{K_ZERO,   OP_ORI,   32'h1234_5678, 32'h0000_0000, 1'b0, 32'h0000_0000},
      '{K_BRANCH, OP_BEQ,   32'h0000_0005, 32'h0000_0005, 1'b0, 32'h0000_0001},
      '{K_BRANCH, OP_BEQ,   32'h0000_0005, 32'h0000_0006, 1'b0, 32'h0000_0002},
      '{K_BRANCH, OP_BNE,   32'h0000_0005, 32'h0000_0005, 1'b0, 32'h0000_0002},
      '{K_BRANCH, OP_BNE,   32'h0000_0005, 32'h0000_0006, 1'b0, 32'h0000_0001},
      '{K_JUMP,   OP_J,     32'h1357_9bdf, 32'h0000_0000, 1'b0, 32'h1357_9bdf},
      '{K_RSVD,   6'h3f,    32'hdead_beef, 32'h0000_0000, 1'b0, 32'h5a5a_c000},
      // random operands with the expected value from the model
      '{K_RTYPE,  F_SUBU,   32'h0,         32'h0,         1'b1, 32'h0},
      '{K_RTYPE,  F_SLT,    32'h0,         32'h0,         1'b1, 32'h0},
      '{K_RTYPE,  F_SRA,    32'h0,         32'h0,         1'b1, 32'h0},
      '{K_ITYPE,  OP_ADDIU, 32'h0,         32'h0,         1'b1, 32'h0},
      '{K_BRANCH, OP_BNE,   32'h0,         32'h0,         1'b1, 32'h0}
   };

   logic            clk = 1'b0;
   logic            rst_b;
   logic [29:0]     inst_addr;
   logic [31:0]     inst;
   dmem_req_t       dmem_req;
   logic [31:0]     dmem_rdata;
   logic            halted;
   halt_cause_e     halt_cause;

   logic [31:0]     imem [64];
   logic [31:0]     dmem [16];
   logic [5:0]      wp;
   logic [31:0]     lfsr;
   logic [29:0]     held_addr;
   row_t            cur;
   int              errors;
   int              row_n;
   int              cycles;

   always #5 clk = ~clk;

   mips_core i_dut (
      .clk(clk), .rst_b(rst_b), .inst_addr(inst_addr), .inst(inst),
      .dmem_req(dmem_req), .dmem_rdata(dmem_rdata), .halted(halted), .halt_cause(halt_cause)
   );

   // both memories answer in the same cycle
   assign inst       = imem[inst_addr[5:0]];
   assign dmem_rdata = dmem[dmem_req.addr[3:0]];

   always @(posedge clk) begin
      if (dmem_req.we) begin
         dmem[dmem_req.addr[3:0]] <= dmem_req.wdata;
      end
   end

   function automatic logic [31:0] r_word(input logic [4:0] rs, input logic [4:0] rt,
                                          input logic [4:0] rd, input logic [4:0] shamt,
                                          input logic [5:0] funct);
      return {6'h00, rs, rt, rd, shamt, funct};
   endfunction

   function automatic logic [31:0] i_word(input logic [5:0] op, input logic [4:0] rs,
                                          input logic [4:0] rt, input logic [15:0] imm);
      return {op, rs, rt, imm};
   endfunction

   // absolute jump to a word slot of the program
   function automatic logic [31:0] j_word(input logic [5:0] slot);
      return {OP_J, TEXT_WORD[25:0] + {20'h0, slot}};
   endfunction

   // marker contents unique per word
   function automatic logic [31:0] fill_word(input logic [3:0] idx);
      return 32'h5a5a_c000 | {28'h0, idx};
   endfunction

   function automatic logic [31:0] galois_step(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
   endfunction

   // one lfsr step per bit
   task automatic draw_word(output logic [31:0] w);
      w = '0;
      for (int i = 0; i < 32; i++) begin
         w    = {w[30:0], lfsr[0]};
         lfsr = galois_step(lfsr);
      end
   endtask

   // ISA rules for the value that lands in data word 0
   function automatic logic [31:0] ref_result(input row_t r);
      logic [31:0] se;
      logic [31:0] ze;
      logic [31:0] sign_fill;
      se = {{16{r.b[15]}}, r.b[15:0]};
      ze = {16'h0000, r.b[15:0]};
      // vacated upper bits of an arithmetic right shift copy the sign
      sign_fill = r.b[31] ? ~(32'hffff_ffff >> r.a[4:0]) : 32'h0;
      case (r.kind)
         K_RTYPE: begin
            case (r.code)
               F_ADDU:  return r.a + r.b;
               F_SUBU:  return r.a - r.b;
               F_AND:   return r.a & r.b;
               F_OR:    return r.a | r.b;
               F_XOR:   return r.a ^ r.b;
               F_NOR:   return ~(r.a | r.b);
               // with differing signs the negative operand is the smaller
               F_SLT:   return (r.a[31] != r.b[31]) ? {31'h0, r.a[31]}
                                                    : ((r.a < r.b) ? 32'd1 : 32'd0);
               F_SLTU:  return (r.a < r.b) ? 32'd1 : 32'd0;
               // shift amount rides in a and the value in b
               F_SLL:   return r.b << r.a[4:0];
               F_SRL:   return r.b >> r.a[4:0];
               F_SRA:   return (r.b >> r.a[4:0]) | sign_fill;
               default: return 32'h0;
            endcase
         end
         K_ITYPE: begin
            case (r.code)
               OP_ADDIU: return r.a + se;
               OP_ANDI:  return r.a & ze;
               OP_ORI:   return r.a | ze;
               OP_XORI:  return r.a ^ ze;
               OP_LUI:   return {r.b[15:0], 16'h0000};
               default:  return 32'h0;
            endcase
         end
         K_BRANCH: begin
            if (r.code == OP_BEQ) begin
               return (r.a == r.b) ? 32'd1 : 32'd2;
            end
            return (r.a != r.b) ? 32'd1 : 32'd2;
         end
         K_MEM, K_JUMP: return r.a;
         K_RSVD:        return fill_word(4'd0);
         default:       return 32'h0;
      endcase
   endfunction

   task automatic emit(input logic [31:0] w);
      imem[wp] = w;
      wp       = wp + 6'd1;
   endtask

   // lui and ori build any 32-bit constant
   task automatic load_reg(input logic [4:0] rt, input logic [31:0] v);
      emit(i_word(OP_LUI, 5'd0, rt, v[31:16]));
      emit(i_word(OP_ORI, rt, rt, v[15:0]));
   endtask

   task automatic build_program(input row_t r);
      // reserved words everywhere so a stray fetch halts with the wrong cause
      for (int i = 0; i < 64; i++) begin
         imem[i[5:0]] = 32'hfc00_0000 | {26'h0, i[5:0]};
      end
      for (int i = 0; i < 16; i++) begin
         dmem[i[3:0]] <= fill_word(i[3:0]);
      end
      wp = 6'd0;
      load_reg(5'd1, r.a);
      case (r.kind)
         K_RTYPE, K_ITYPE, K_BRANCH: load_reg(5'd2, r.b);
         default: ;
      endcase
      case (r.kind)
         K_RTYPE: begin
            if (r.code == F_SLL || r.code == F_SRL || r.code == F_SRA) begin
               emit(r_word(5'd0, 5'd2, 5'd3, r.a[4:0], r.code));
            end else begin
               emit(r_word(5'd1, 5'd2, 5'd3, 5'd0, r.code));
            end
            emit(i_word(OP_SW, 5'd0, 5'd3, 16'd0));
         end
         K_ITYPE: begin
            emit(i_word(r.code, (r.code == OP_LUI) ? 5'd0 : 5'd1, 5'd3, r.b[15:0]));
            emit(i_word(OP_SW, 5'd0, 5'd3, 16'd0));
         end
         K_MEM: begin
            emit(i_word(OP_SW, 5'd0, 5'd1, 16'd0));
            emit(i_word(OP_LW, 5'd0, 5'd4, 16'd0));
            emit(i_word(OP_SW, 5'd0, 5'd4, 16'd4));
         end
         K_ZERO: begin
            emit(i_word(OP_ORI, 5'd1, 5'd0, 16'h0001));
            emit(i_word(OP_SW, 5'd0, 5'd0, 16'd0));
         end
         K_BRANCH: begin
            // slot 4 branches to slot 7 and slot 6 jumps over it to the store
            emit(i_word(r.code, 5'd1, 5'd2, 16'd2));
            emit(i_word(OP_ORI, 5'd0, 5'd5, 16'd2));
            emit(j_word(6'd8));
            emit(i_word(OP_ORI, 5'd0, 5'd5, 16'd1));
            emit(i_word(OP_SW, 5'd0, 5'd5, 16'd0));
         end
         K_JUMP: begin
            emit(j_word(6'd4));
            emit(i_word(OP_SW, 5'd0, 5'd1, 16'd4));
            emit(i_word(OP_SW, 5'd0, 5'd1, 16'd0));
         end
         default: begin
            emit(32'hfc00_0000);
            emit(i_word(OP_SW, 5'd0, 5'd1, 16'd0));
         end
      endcase
      emit(r_word(5'd0, 5'd0, 5'd0, 5'd0, F_SYSCALL));
   endtask

   task automatic check_word(input logic [3:0] idx, input logic [31:0] want);
      assert (dmem[idx] === want) else begin
         $display("ERROR %0t: row %0d data word %0d is %h, expected %h",
                  $time, row_n, idx, dmem[idx], want);
         errors++;
      end
   endtask

   task automatic check_cause(input halt_cause_e want);
      assert (halt_cause === want) else begin
         $display("ERROR %0t: row %0d halt cause %s, expected %s",
                  $time, row_n, halt_cause.name(), want.name());
         errors++;
      end
   endtask

   // each row needs well under 40 cycles
   initial begin
      #(NROWS * 40 * 10);
      $display("watchdog expired before all rows finished");
      $display("TEST FAILED");
      $finish;
   end

   initial begin
      rst_b  = 1'b0;
      errors = 0;
      lfsr   = LFSR_SEED;
      for (int n = 0; n < NROWS; n++) begin
         row_n = n;
         cur   = ROWS[n];
         if (cur.rnd) begin
            draw_word(cur.a);
            draw_word(cur.b);
            cur.want = ref_result(cur);
         end
         rst_b = 1'b0;
         build_program(cur);
         repeat (16) @(posedge clk);
         #1 rst_b = 1'b1;
         cycles = 0;
         while (!halted && cycles < 64) begin
            @(posedge clk);
            #1 cycles++;
         end
         assert (halted) else begin
            $display("row %0d: core did not halt within 64 cycles", n);
            errors++;
         end
         check_word(4'd0, cur.want);
         case (cur.kind)
            K_MEM: check_word(4'd1, cur.a);
            // the skipped store leaves its marker
            K_JUMP: check_word(4'd1, fill_word(4'd1));
            default: ;
         endcase
         if (cur.kind == K_RSVD) begin
            check_cause(HALT_RESERVED);
            held_addr = inst_addr;
            assert (held_addr == TEXT_WORD + 30'd2) else begin
               $display("ERROR %0t: row %0d halted at %h, expected %h",
                        $time, n, held_addr, TEXT_WORD + 30'd2);
               errors++;
            end
            repeat (10) begin
               @(posedge clk);
               #1;
               assert (inst_addr == held_addr) else begin
                  $display("ERROR %0t: row %0d fetch address moved to %h after halt",
                           $time, n, inst_addr);
                  errors++;
               end
            end
         end else begin
            check_cause(HALT_SYSCALL);
         end
      end
      $display("rows run: %0d, errors: %0d", NROWS, errors);
      if (errors == 0) begin
         $display("TEST OK");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== common/mips_cfg.svh ====
// MIPS core configuration
`ifndef MIPS_CFG_SVH
`define MIPS_CFG_SVH

// first fetch address after reset
`define MIPS_TEXT_START 32'h00400000

// datapath width
`define MIPS_XLEN 32

// register file addressing
`define MIPS_REG_AW 5
`define MIPS_NUM_REGS 32

// word address width on the memory ports
// byte offset bits are dropped
`define MIPS_IADDR_W 30

`endif

// ==== common/mips_ctrl_pkg.sv ====
// MIPS control and memory types
`default_nettype none

`include "mips_cfg.svh"

package mips_ctrl_pkg;

   typedef enum logic [3:0] {
      ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_NOR,
      ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA
   } alu_op_e;

   // next pc source with branches resolved in fetch
   typedef enum logic [1:0] {PC_SEQ, PC_BEQ, PC_BNE, PC_JUMP} pc_sel_e;

   typedef enum logic [1:0] {HALT_NONE, HALT_SYSCALL, HALT_RESERVED} halt_cause_e;

   // decoded control for one instruction
   typedef struct packed {
      alu_op_e alu_op;
      logic    alu_src_imm;
      logic    imm_sign;
      logic    shift_imm;
      logic    reg_dst_rd;
      logic    reg_we;
      logic    mem_to_reg;
      logic    mem_we;
      logic    is_lui;
      pc_sel_e pc_sel;
      logic    is_syscall;
   } ctrl_t;

   // full-word data memory request
   typedef struct packed {
      logic [`MIPS_IADDR_W-1:0] addr;
      logic [`MIPS_XLEN-1:0]    wdata;
      logic                     we;
   } dmem_req_t;

endpackage

`default_nettype wire

// ==== common/mips_isa_pkg.sv ====
// MIPS instruction encodings
`default_nettype none

package mips_isa_pkg;

   // primary opcodes of the supported subset
   typedef enum logic [5:0] {
      OP_SPECIAL = 6'h00,
      OP_J       = 6'h02,
      OP_BEQ     = 6'h04,
      OP_BNE     = 6'h05,
      OP_ADDIU   = 6'h09,
      OP_ANDI    = 6'h0c,
      OP_ORI     = 6'h0d,
      OP_XORI    = 6'h0e,
      OP_LUI     = 6'h0f,
      OP_LW      = 6'h23,
      OP_SW      = 6'h2b
   } op_e;

   // funct codes under OP_SPECIAL
   typedef enum logic [5:0] {
      F_SLL     = 6'h00,
      F_SRL     = 6'h02,
      F_SRA     = 6'h03,
      F_SYSCALL = 6'h0c,
      F_ADDU    = 6'h21,
      F_SUBU    = 6'h23,
      F_AND     = 6'h24,
      F_OR      = 6'h25,
      F_XOR     = 6'h26,
      F_NOR     = 6'h27,
      F_SLT     = 6'h2a,
      F_SLTU    = 6'h2b
   } funct_e;

   // r-type field layout
   typedef struct packed {
      op_e        op;
      logic [4:0] rs;
      logic [4:0] rt;
      logic [4:0] rd;
      logic [4:0] shamt;
      funct_e     funct;
   } inst_t;

   // same 32 bits seen as r, i or j format
   typedef union packed {
      inst_t r;
      struct packed {
         logic [5:0]  op;
         logic [4:0]  rs;
         logic [4:0]  rt;
         logic [15:0] imm;
      } i;
      struct packed {
         logic [5:0]  op;
         logic [25:0] target;
      } j;
   } inst_u;

endpackage

`default_nettype wire

// ==== decode/mips_decode.sv ====
// MIPS instruction decoder
`timescale 1ns/1ps
`default_nettype none

module mips_decode
   import mips_isa_pkg::*, mips_ctrl_pkg::*;
(
   input  inst_u inst,
   output ctrl_t ctrl,
   output logic  reserved
);

   always_comb begin
      // safe defaults with no writes and a sequential pc
      ctrl        = '0;
      ctrl.alu_op = ALU_ADD;
      ctrl.pc_sel = PC_SEQ;
      reserved    = 1'b0;
      case (inst.r.op)
         OP_SPECIAL: begin
            ctrl.reg_dst_rd = 1'b1;
            ctrl.reg_we     = 1'b1;
            case (inst.r.funct)
               F_ADDU: ctrl.alu_op = ALU_ADD;
               F_SUBU: ctrl.alu_op = ALU_SUB;
               F_AND:  ctrl.alu_op = ALU_AND;
               F_OR:   ctrl.alu_op = ALU_OR;
               F_XOR:  ctrl.alu_op = ALU_XOR;
               F_NOR:  ctrl.alu_op = ALU_NOR;
               F_SLT:  ctrl.alu_op = ALU_SLT;
               F_SLTU: ctrl.alu_op = ALU_SLTU;
               // shifts take shamt from the instruction
               F_SLL: begin
                  ctrl.alu_op    = ALU_SLL;
                  ctrl.shift_imm = 1'b1;
               end
               F_SRL: begin
                  ctrl.alu_op    = ALU_SRL;
                  ctrl.shift_imm = 1'b1;
               end
               F_SRA: begin
                  ctrl.alu_op    = ALU_SRA;
                  ctrl.shift_imm = 1'b1;
               end
               F_SYSCALL: begin
                  ctrl.reg_we     = 1'b0;
                  ctrl.is_syscall = 1'b1;
               end
               default: begin
                  ctrl.reg_we     = 1'b0;
                  ctrl.reg_dst_rd = 1'b0;
                  reserved        = 1'b1;
               end
            endcase
         end
         OP_ADDIU: begin
            ctrl.alu_src_imm = 1'b1;
            ctrl.imm_sign    = 1'b1;
            ctrl.reg_we      = 1'b1;
         end
         // logic immediates are zero extended
         OP_ANDI: begin
            ctrl.alu_op      = ALU_AND;
            ctrl.alu_src_imm = 1'b1;
            ctrl.reg_we      = 1'b1;
         end
         OP_ORI: begin
            ctrl.alu_op      = ALU_OR;
            ctrl.alu_src_imm = 1'b1;
            ctrl.reg_we      = 1'b1;
         end
         OP_XORI: begin
            ctrl.alu_op      = ALU_XOR;
            ctrl.alu_src_imm = 1'b1;
            ctrl.reg_we      = 1'b1;
         end
         OP_LUI: begin
            ctrl.is_lui = 1'b1;
            ctrl.reg_we = 1'b1;
         end
         // address is rs plus sign-extended offset
         OP_LW: begin
            ctrl.alu_src_imm = 1'b1;
            ctrl.imm_sign    = 1'b1;
            ctrl.mem_to_reg  = 1'b1;
            ctrl.reg_we      = 1'b1;
         end
         OP_SW: begin
            ctrl.alu_src_imm = 1'b1;
            ctrl.imm_sign    = 1'b1;
            ctrl.mem_we      = 1'b1;
         end
         OP_BEQ: begin
            ctrl.alu_op = ALU_SUB;
            ctrl.pc_sel = PC_BEQ;
         end
         OP_BNE: begin
            ctrl.alu_op = ALU_SUB;
            ctrl.pc_sel = PC_BNE;
         end
         OP_J: ctrl.pc_sel = PC_JUMP;
         default: reserved = 1'b1;
      endcase
   end

   // a reserved encoding must never reach a register or memory write
   always_comb begin
      if (reserved) begin
         assert (!ctrl.reg_we && !ctrl.mem_we)
            else $error("reserved instruction carries a write enable");
      end
   end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# build and run the core testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module tb_mips_core -f tb.f -o tb_mips_core
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

out=$(./obj_dir/tb_mips_core)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if echo "$out" | grep -q "^TEST OK$"; then
   exit 0
fi
exit 1

// ==== tb.f ====
+incdir+common
common/mips_isa_pkg.sv
common/mips_ctrl_pkg.sv
decode/mips_decode.sv
verilog/mips_regfile.sv
verilog/mips_alu.sv
verilog/mips_fetch.sv
verilog/mips_core.sv
bench/tb_mips_core.sv

// ==== verilog/mips_alu.sv ====
// MIPS integer ALU
`timescale 1ns/1ps
`default_nettype none

`include "mips_cfg.svh"

module mips_alu
   import mips_ctrl_pkg::*;
(
   input  logic [`MIPS_XLEN-1:0] op_a,
   input  logic [`MIPS_XLEN-1:0] op_b,
   input  logic [4:0]            shamt,
   input  alu_op_e               alu_op,
   output logic [`MIPS_XLEN-1:0] result,
   output logic                  zero
);

   always_comb begin
      case (alu_op)
         // addu and subu semantics without overflow traps
         ALU_ADD:  result = op_a + op_b;
         ALU_SUB:  result = op_a - op_b;
         ALU_AND:  result = op_a & op_b;
         ALU_OR:   result = op_a | op_b;
         ALU_XOR:  result = op_a ^ op_b;
         ALU_NOR:  result = ~(op_a | op_b);
         ALU_SLT: begin
            result = {31'b0, $signed(op_a) < $signed(op_b)};
         end
         ALU_SLTU: begin
            result = {31'b0, op_a < op_b};
         end
         // shifts act on op_b which carries rt
         ALU_SLL:  result = op_b << shamt;
         ALU_SRL:  result = op_b >> shamt;
         ALU_SRA:  result = $unsigned($signed(op_b) >>> shamt);
         default:  result = '0;
      endcase
   end

   // equality for beq and bne
   assign zero = (op_a == op_b);

endmodule

`default_nettype wire

// ==== verilog/mips_core.sv ====
// Single-cycle MIPS core
`timescale 1ns/1ps
`default_nettype none

`include "mips_cfg.svh"

module mips_core
   import mips_isa_pkg::*, mips_ctrl_pkg::*;
(
   input  logic                     clk,
   input  logic                     rst_b,
   output logic [`MIPS_IADDR_W-1:0] inst_addr,
   input  logic [`MIPS_XLEN-1:0]    inst,
   output dmem_req_t                dmem_req,
   input  logic [`MIPS_XLEN-1:0]    dmem_rdata,
   output logic                     halted,
   output halt_cause_e              halt_cause
);

   inst_u                  inst_w;
   ctrl_t                  ctrl;
   logic                   reserved;
   logic [`MIPS_XLEN-1:0]  pc;
   logic [`MIPS_XLEN-1:0]  rs_data;
   logic [`MIPS_XLEN-1:0]  rt_data;
   logic [`MIPS_XLEN-1:0]  imm_ext;
   logic [`MIPS_XLEN-1:0]  alu_b;
   logic [`MIPS_XLEN-1:0]  alu_result;
   logic [`MIPS_XLEN-1:0]  wb_data;
   logic [`MIPS_REG_AW-1:0] wb_addr;
   logic [4:0]             alu_shamt;
   logic                   alu_zero;
   logic                   wr_ok;

   assign inst_w    = inst;
   assign inst_addr = pc[`MIPS_XLEN-1:2];

   mips_fetch i_fetch (
      .clk(clk), .rst_b(rst_b), .pc_sel(ctrl.pc_sel), .zero(alu_zero),
      .imm(inst_w.i.imm), .target(inst_w.j.target), .is_syscall(ctrl.is_syscall),
      .reserved(reserved), .pc(pc), .halted(halted), .halt_cause(halt_cause)
   );

   mips_decode i_decode (.inst(inst_w), .ctrl(ctrl), .reserved(reserved));

   // no register or memory writes in reset or once halted
   assign wr_ok = rst_b & ~halted;

   mips_regfile i_regfile (
      .clk(clk), .rst_b(rst_b), .raddr_a(inst_w.r.rs), .raddr_b(inst_w.r.rt),
      .rdata_a(rs_data), .rdata_b(rt_data), .waddr(wb_addr), .wdata(wb_data),
      .we(ctrl.reg_we & wr_ok)
   );

   // sign or zero extension of the 16-bit immediate
   assign imm_ext   = ctrl.imm_sign ? {{16{inst_w.i.imm[15]}}, inst_w.i.imm}
                                    : {16'h0000, inst_w.i.imm};
   assign alu_b     = ctrl.alu_src_imm ? imm_ext : rt_data;
   // variable shift amount comes from rs
   assign alu_shamt = ctrl.shift_imm ? inst_w.r.shamt : rs_data[4:0];

   mips_alu i_alu (
      .op_a(rs_data), .op_b(alu_b), .shamt(alu_shamt), .alu_op(ctrl.alu_op),
      .result(alu_result), .zero(alu_zero)
   );

   // write-back select
   assign wb_addr = ctrl.reg_dst_rd ? inst_w.r.rd : inst_w.r.rt;
   assign wb_data = ctrl.is_lui     ? {inst_w.i.imm, 16'h0000} :
                    ctrl.mem_to_reg ? dmem_rdata : alu_result;

   // word-addressed data port
   assign dmem_req.addr  = alu_result[`MIPS_XLEN-1:2];
   assign dmem_req.wdata = rt_data;
   assign dmem_req.we    = ctrl.mem_we & wr_ok;

   // halting instruction and everything after it leave memory alone
   a_no_write_halted: assert property (@(posedge clk) disable iff (!rst_b)
      (halted || ctrl.is_syscall || reserved) |-> !dmem_req.we);

endmodule

`default_nettype wire

// ==== verilog/mips_fetch.sv ====
// PC and halt control
`timescale 1ns/1ps
`default_nettype none

`include "mips_cfg.svh"

module mips_fetch
   import mips_ctrl_pkg::*;
(
   input  logic                  clk,
   input  logic                  rst_b,
   input  pc_sel_e               pc_sel,
   input  logic                  zero,
   input  logic [15:0]           imm,
   input  logic [25:0]           target,
   input  logic                  is_syscall,
   input  logic                  reserved,
   output logic [`MIPS_XLEN-1:0] pc,
   output logic                  halted,
   output halt_cause_e           halt_cause
);

   logic [`MIPS_XLEN-1:0] pc_plus4;
   logic [`MIPS_XLEN-1:0] br_target;
   logic [`MIPS_XLEN-1:0] jmp_target;
   logic [`MIPS_XLEN-1:0] pc_next;

   assign pc_plus4   = pc + 32'd4;
   // sign-extended word offset relative to the delay slot address
   assign br_target  = pc_plus4 + {{14{imm[15]}}, imm, 2'b00};
   // region bits come from pc+4
   assign jmp_target = {pc_plus4[31:28], target, 2'b00};

   always_comb begin
      case (pc_sel)
         PC_BEQ:  pc_next = zero ? br_target : pc_plus4;
         PC_BNE:  pc_next = zero ? pc_plus4 : br_target;
         PC_JUMP: pc_next = jmp_target;
         default: pc_next = pc_plus4;
      endcase
   end

   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         pc         <= `MIPS_TEXT_START;
         halted     <= 1'b0;
         halt_cause <= HALT_NONE;
      end else if (!halted) begin
         // pc stays on the halting instruction
         if (is_syscall || reserved) begin
            halted     <= 1'b1;
            halt_cause <= reserved ? HALT_RESERVED : HALT_SYSCALL;
         end else begin
            pc <= pc_next;
         end
      end
   end

   a_pc_aligned: assert property (@(posedge clk) disable iff (!rst_b) pc[1:0] == 2'b00);

endmodule

`default_nettype wire

// ==== verilog/mips_regfile.sv ====
// MIPS register file
`timescale 1ns/1ps
`default_nettype none

`include "mips_cfg.svh"

module mips_regfile (
   input  logic                    clk,
   input  logic                    rst_b,
   input  logic [`MIPS_REG_AW-1:0] raddr_a,
   input  logic [`MIPS_REG_AW-1:0] raddr_b,
   output logic [`MIPS_XLEN-1:0]   rdata_a,
   output logic [`MIPS_XLEN-1:0]   rdata_b,
   input  logic [`MIPS_REG_AW-1:0] waddr,
   input  logic [`MIPS_XLEN-1:0]   wdata,
   input  logic                    we
);

   logic [`MIPS_XLEN-1:0] regs [`MIPS_NUM_REGS];

   always_ff @(posedge clk or negedge rst_b) begin
      if (!rst_b) begin
         for (int i = 0; i < `MIPS_NUM_REGS; i++) begin
            regs[i] <= '0;
         end
      end else if (we && waddr != '0) begin
         // $zero is never written
         regs[waddr] <= wdata;
      end
   end

   // combinational reads
   // $zero keeps its reset value because writes skip it
   assign rdata_a = regs[raddr_a];
   assign rdata_b = regs[raddr_b];

   a_zero_reg: assert property (@(posedge clk) disable iff (!rst_b)
      raddr_a == '0 |-> rdata_a == '0);

endmodule

`default_nettype wire
